// ==== verilog/rv32i_types.sv ====
package rv32i_types;

    // reorder buffer tag width
    localparam int rob_idx_w = 5;

    // branch station sizing
    localparam int br_rs_depth = 4;
    localparam int br_rs_ptr_w = $clog2(br_rs_depth);

    // major opcodes resolved by the branch cluster
    typedef enum logic [6:0] {
        op_b_jal  = 7'b1101111,
        op_b_jalr = 7'b1100111,
        op_b_br   = 7'b1100011
    } br_opcode_t;

    // funct3 of the conditional branches
    typedef enum logic [2:0] {
        branch_f3_beq  = 3'b000,
        branch_f3_bne  = 3'b001,
        branch_f3_blt  = 3'b100,
        branch_f3_bge  = 3'b101,
        branch_f3_bltu = 3'b110,
        branch_f3_bgeu = 3'b111
    } branch_f3_t;

    // written by dispatch, operands may still be pending on a rob tag
    typedef struct packed {
        logic                 valid;
        logic [31:0]          pc;
        logic [31:0]          inst;
        br_opcode_t           opcode;
        branch_f3_t           brop;
        logic [31:0]          imm_sext;
        logic [4:0]           rs1_addr;
        logic [4:0]           rs2_addr;
        logic [4:0]           rd_addr;
        logic                 regf_we;
        logic [rob_idx_w-1:0] rd_rob_idx;
        logic                 rs1_ready;
        logic [31:0]          rs1_data;
        logic [rob_idx_w-1:0] rs1_rob_idx;
        logic                 rs2_ready;
        logic [31:0]          rs2_data;
        logic [rob_idx_w-1:0] rs2_rob_idx;
        logic [31:0]          pc_new;
    } br_dispatch_t;

    // issued entry, both operands resolved
    typedef struct packed {
        logic                 valid;
        logic [31:0]          pc;
        logic [31:0]          inst;
        br_opcode_t           opcode;
        branch_f3_t           brop;
        logic [31:0]          imm_sext;
        logic [4:0]           rs1_addr;
        logic [4:0]           rs2_addr;
        logic [4:0]           rd_addr;
        logic                 regf_we;
        logic [rob_idx_w-1:0] rd_rob_idx;
        logic [31:0]          rs1_data;
        logic [31:0]          rs2_data;
        logic [31:0]          pc_new;
    } reservation_station_t;

    // result broadcast from the other execute units
    typedef struct packed {
        logic                 valid;
        logic [rob_idx_w-1:0] rob_idx;
        logic [31:0]          data;
    } cdb_wake_t;

    // result towards the reorder buffer
    typedef struct packed {
        logic                 valid;
        logic [31:0]          pc;
        logic [31:0]          inst;
        logic [4:0]           rd_addr;
        logic [4:0]           rs1_addr;
        logic [4:0]           rs2_addr;
        logic [rob_idx_w-1:0] rd_rob_idx;
        logic [31:0]          rd_data;
        logic                 regf_we;
        logic                 br_en;
        logic [31:0]          pc_new;
    } to_writeback_t;

endpackage

// ==== verilog/br_station.sv ====
`timescale 1ns/1ps

module br_station (
    input  logic                              clk,
    input  logic                              rst_n,
    input  rv32i_types::br_dispatch_t         dispatch_in,
    input  rv32i_types::cdb_wake_t            cdb_in,
    input  logic                              wb_stall,
    input  logic                              flush,
    output rv32i_types::reservation_station_t issue_entry,
    output logic                              station_full
);

    // entry storage, meaning given by head/count only
    rv32i_types::br_dispatch_t entries [rv32i_types::br_rs_depth];

    logic [rv32i_types::br_rs_ptr_w-1:0] head;
    logic [rv32i_types::br_rs_ptr_w-1:0] tail;
    logic [rv32i_types::br_rs_ptr_w:0]   count;

    rv32i_types::br_dispatch_t head_entry;
    rv32i_types::br_dispatch_t disp_entry;
    logic                      head_ready;
    logic                      do_issue;
    logic                      do_dispatch;

    assign station_full = (count == (rv32i_types::br_rs_ptr_w + 1)'(rv32i_types::br_rs_depth));

    assign head_entry = entries[head];
    assign head_ready = (count != '0) && head_entry.rs1_ready && head_entry.rs2_ready;

    // strict program order, only the head may leave
    assign do_issue    = head_ready && !wb_stall && !flush;
    // a dispatch during the redirect cycle is younger than the taken branch
    assign do_dispatch = dispatch_in.valid && !station_full && !flush;

    // operand capture when the broadcast lands in the dispatch cycle
    always_comb begin
        disp_entry = dispatch_in;
        if (cdb_in.valid && !dispatch_in.rs1_ready &&
            (dispatch_in.rs1_rob_idx == cdb_in.rob_idx)) begin
            disp_entry.rs1_ready = 1'b1;
            disp_entry.rs1_data  = cdb_in.data;
        end
        if (cdb_in.valid && !dispatch_in.rs2_ready &&
            (dispatch_in.rs2_rob_idx == cdb_in.rob_idx)) begin
            disp_entry.rs2_ready = 1'b1;
            disp_entry.rs2_data  = cdb_in.data;
        end
    end

    // head presented to the branch unit
    always_comb begin
        issue_entry            = '0;
        issue_entry.valid      = do_issue;
        issue_entry.pc         = head_entry.pc;
        issue_entry.inst       = head_entry.inst;
        issue_entry.opcode     = head_entry.opcode;
        issue_entry.brop       = head_entry.brop;
        issue_entry.imm_sext   = head_entry.imm_sext;
        issue_entry.rs1_addr   = head_entry.rs1_addr;
        issue_entry.rs2_addr   = head_entry.rs2_addr;
        issue_entry.rd_addr    = head_entry.rd_addr;
        issue_entry.regf_we    = head_entry.regf_we;
        issue_entry.rd_rob_idx = head_entry.rd_rob_idx;
        issue_entry.rs1_data   = head_entry.rs1_data;
        issue_entry.rs2_data   = head_entry.rs2_data;
        issue_entry.pc_new     = head_entry.pc_new;
    end

    // cdb wakeup on every slot, then the new entry at the tail
    always_ff @(posedge clk) begin
        for (int i = 0; i < rv32i_types::br_rs_depth; i++) begin
            if (cdb_in.valid && !entries[i].rs1_ready &&
                (entries[i].rs1_rob_idx == cdb_in.rob_idx)) begin
                entries[i].rs1_ready <= 1'b1;
                entries[i].rs1_data  <= cdb_in.data;
            end
            if (cdb_in.valid && !entries[i].rs2_ready &&
                (entries[i].rs2_rob_idx == cdb_in.rob_idx)) begin
                entries[i].rs2_ready <= 1'b1;
                entries[i].rs2_data  <= cdb_in.data;
            end
        end
        // tail slot is free, so the wakeup above never targets it
        if (do_dispatch) begin
            entries[tail] <= disp_entry;
        end
    end

    // queue pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // everything queued is younger than the taken branch
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_dispatch) begin
                tail <= tail + 1'b1;
            end
            if (do_issue) begin
                head <= head + 1'b1;
            end
            if (do_dispatch && !do_issue) begin
                count <= count + 1'b1;
            end else if (do_issue && !do_dispatch) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== verilog/br_unit.sv ====
`timescale 1ns/1ps

module br_unit (
    input  logic                              clk,
    input  logic                              rst_n,
    input  rv32i_types::reservation_station_t next_execute,
    output rv32i_types::to_writeback_t        execute_output
);

    // clk and rst_n kept for the common execute-unit port list
    // resolution itself is purely combinational

    logic [31:0]        base;
    logic [31:0]        offset;
    logic [31:0]        target;
    logic [31:0]        link;
    logic               taken;
    logic signed [31:0] rs1_s;
    logic signed [31:0] rs2_s;

    assign rs1_s = $signed(next_execute.rs1_data);
    assign rs2_s = $signed(next_execute.rs2_data);

    // target operands, taken flag and link value
    always_comb begin
        base   = '0;
        offset = '0;
        taken  = 1'b0;
        link   = '0;

        if (next_execute.valid) begin
            case (next_execute.opcode)
                rv32i_types::op_b_jal: begin
                    base   = next_execute.pc;
                    offset = next_execute.imm_sext;
                    taken  = 1'b1;
                    link   = next_execute.pc + 32'd4;
                end
                rv32i_types::op_b_jalr: begin
                    base   = next_execute.rs1_data;
                    offset = next_execute.imm_sext;
                    taken  = 1'b1;
                    link   = next_execute.pc + 32'd4;
                end
                rv32i_types::op_b_br: begin
                    base   = next_execute.pc;
                    offset = next_execute.imm_sext;
                    // conditional branches write no register
                    case (next_execute.brop)
                        rv32i_types::branch_f3_beq:  taken = (rs1_s == rs2_s);
                        rv32i_types::branch_f3_bne:  taken = (rs1_s != rs2_s);
                        rv32i_types::branch_f3_blt:  taken = (rs1_s < rs2_s);
                        rv32i_types::branch_f3_bge:  taken = (rs1_s >= rs2_s);
                        rv32i_types::branch_f3_bltu: begin
                            taken = (next_execute.rs1_data < next_execute.rs2_data);
                        end
                        rv32i_types::branch_f3_bgeu: begin
                            taken = (next_execute.rs1_data >= next_execute.rs2_data);
                        end
                        default: taken = 1'b0;
                    endcase
                end
                default: begin
                    base   = '0;
                    offset = '0;
                end
            endcase
        end

        target = base + offset;
    end

    // result record, all zero when nothing issues
    always_comb begin
        execute_output = '0;

        if (next_execute.valid) begin
            execute_output.valid      = 1'b1;
            execute_output.pc         = next_execute.pc;
            execute_output.inst       = next_execute.inst;
            execute_output.rd_addr    = next_execute.rd_addr;
            execute_output.rs1_addr   = next_execute.rs1_addr;
            execute_output.rs2_addr   = next_execute.rs2_addr;
            execute_output.rd_rob_idx = next_execute.rd_rob_idx;
            execute_output.rd_data    = link;
            execute_output.regf_we    = next_execute.regf_we;
            execute_output.br_en      = taken;
            // predicted not taken, so the fall-through stays when not taken
            if (taken) begin
                execute_output.pc_new = target;
            end else begin
                execute_output.pc_new = next_execute.pc_new;
            end
        end
    end

endmodule

// ==== verilog/br_complete.sv ====
`timescale 1ns/1ps

module br_complete (
    input  logic                       clk,
    input  logic                       rst_n,
    input  rv32i_types::to_writeback_t resolved,
    input  logic                       wb_stall,
    output rv32i_types::to_writeback_t wb_out,
    output logic                       redirect,
    output logic [31:0]                redirect_pc,
    output logic                       flush
);

    // result payload and its valid bit
    rv32i_types::to_writeback_t out_payload;
    logic                       out_valid;
    logic                       load;

    // rob back-pressure freezes the stage
    assign load = !wb_stall;

    always_ff @(posedge clk) begin
        if (load) begin
            out_payload <= resolved;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            // drops back to zero when the station had nothing to issue
            out_valid <= resolved.valid;
        end
    end

    // one pulse per taken result, never again while held
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            redirect <= 1'b0;
        end else begin
            redirect <= load && resolved.valid && resolved.br_en;
        end
    end

    always_comb begin
        wb_out       = out_payload;
        wb_out.valid = out_valid;
    end

    assign redirect_pc = out_payload.pc_new;

    // every taken branch is a mispredict, so the redirect also flushes
    assign flush = redirect;

endmodule

// ==== verilog/br_exec_top.sv ====
`timescale 1ns/1ps

module br_exec_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  rv32i_types::br_dispatch_t  dispatch_in,
    input  rv32i_types::cdb_wake_t     cdb_in,
    input  logic                       wb_stall,
    output logic                       station_full,
    output rv32i_types::to_writeback_t wb_out,
    output logic                       redirect,
    output logic [31:0]                redirect_pc
);

    rv32i_types::reservation_station_t issue_entry;
    rv32i_types::to_writeback_t        resolved;
    logic                              flush;

    // in-order station with cdb wakeup
    br_station i_br_station (
        .clk          (clk),
        .rst_n        (rst_n),
        .dispatch_in  (dispatch_in),
        .cdb_in       (cdb_in),
        .wb_stall     (wb_stall),
        .flush        (flush),
        .issue_entry  (issue_entry),
        .station_full (station_full)
    );

    // same-cycle resolution
    br_unit i_br_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .next_execute   (issue_entry),
        .execute_output (resolved)
    );

    // writeback register and redirect
    br_complete i_br_complete (
        .clk         (clk),
        .rst_n       (rst_n),
        .resolved    (resolved),
        .wb_stall    (wb_stall),
        .wb_out      (wb_out),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .flush       (flush)
    );

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held for 10 cycles, released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

// ==== sim/br_exec_tb.sv ====
`timescale 1ns/1ps

module br_exec_tb;

    localparam int test_count      = 5;
    localparam int cycles_per_test = 400;
    localparam int result_wait     = 50;

    logic                       clk;
    logic                       rst_n;
    rv32i_types::br_dispatch_t  dispatch_in;
    rv32i_types::cdb_wake_t     cdb_in;
    logic                       wb_stall;
    logic                       station_full;
    rv32i_types::to_writeback_t wb_out;
    logic                       redirect;
    logic [31:0]                redirect_pc;

    rv32i_types::to_writeback_t results [$];
    logic [31:0]                redirects [$];
    int                         err_count;
    int                         tests_failed;
    integer                     seed;

    tb_clk_gen i_tb_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    br_exec_top i_br_exec_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .dispatch_in  (dispatch_in),
        .cdb_in       (cdb_in),
        .wb_stall     (wb_stall),
        .station_full (station_full),
        .wb_out       (wb_out),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    // a result counts once in the cycle the rob accepts it
    always @(negedge clk) begin
        if (rst_n === 1'b1 && wb_out.valid === 1'b1 && wb_stall === 1'b0) begin
            results.push_back(wb_out);
        end
        if (rst_n === 1'b1 && redirect === 1'b1) begin
            redirects.push_back(redirect_pc);
        end
    end

    function automatic rv32i_types::br_dispatch_t make_op(
        input rv32i_types::br_opcode_t op,
        input rv32i_types::branch_f3_t f3,
        input logic [31:0]             pc,
        input logic [31:0]             imm,
        input logic [31:0]             a,
        input logic [31:0]             b,
        input logic [4:0]              tag
    );
        rv32i_types::br_dispatch_t d;
        d             = '0;
        d.valid       = 1'b1;
        d.pc          = pc;
        d.inst        = {imm[24:0], op};
        d.opcode      = op;
        d.brop        = f3;
        d.imm_sext    = imm;
        d.rs1_addr    = 5'd3;
        d.rs2_addr    = 5'd4;
        d.rd_addr     = (op == rv32i_types::op_b_br) ? 5'd0 : 5'd1;
        d.regf_we     = (op != rv32i_types::op_b_br);
        d.rd_rob_idx  = tag;
        d.rs1_ready   = 1'b1;
        d.rs1_data    = a;
        d.rs2_ready   = 1'b1;
        d.rs2_data    = b;
        // predict not taken
        d.pc_new      = pc + 32'd4;
        return d;
    endfunction

    // reference model on final operand values
    function automatic rv32i_types::to_writeback_t expected_result(
        input rv32i_types::br_dispatch_t d
    );
        rv32i_types::to_writeback_t w;
        logic                       take;
        w            = '0;
        take         = 1'b0;
        w.valid      = 1'b1;
        w.pc         = d.pc;
        w.inst       = d.inst;
        w.rd_addr    = d.rd_addr;
        w.rs1_addr   = d.rs1_addr;
        w.rs2_addr   = d.rs2_addr;
        w.rd_rob_idx = d.rd_rob_idx;
        w.regf_we    = d.regf_we;
        if (d.opcode == rv32i_types::op_b_jal || d.opcode == rv32i_types::op_b_jalr) begin
            take      = 1'b1;
            w.rd_data = d.pc + 32'd4;
            if (d.opcode == rv32i_types::op_b_jal) begin
                w.pc_new = d.pc + d.imm_sext;
            end else begin
                w.pc_new = d.rs1_data + d.imm_sext;
            end
        end else begin
            case (d.brop)
                rv32i_types::branch_f3_beq:  take = (d.rs1_data == d.rs2_data);
                rv32i_types::branch_f3_bne:  take = (d.rs1_data != d.rs2_data);
                rv32i_types::branch_f3_blt:  take = ($signed(d.rs1_data) < $signed(d.rs2_data));
                rv32i_types::branch_f3_bge:  take = ($signed(d.rs1_data) >= $signed(d.rs2_data));
                rv32i_types::branch_f3_bltu: take = (d.rs1_data < d.rs2_data);
                default:                     take = (d.rs1_data >= d.rs2_data);
            endcase
            w.pc_new = take ? (d.pc + d.imm_sext) : d.pc_new;
        end
        w.br_en = take;
        return w;
    endfunction

    // all tasks start and end 2 ns after a rising edge
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic drive_dispatch(input rv32i_types::br_dispatch_t d);
        dispatch_in = d;
        idle_cycles(1);
        dispatch_in = '0;
    endtask

    task automatic broadcast_cdb(input logic [4:0] tag, input logic [31:0] data);
        cdb_in.valid   = 1'b1;
        cdb_in.rob_idx = tag;
        cdb_in.data    = data;
        idle_cycles(1);
        cdb_in = '0;
    endtask

    task automatic clear_queues();
        results.delete();
        redirects.delete();
    endtask

    task automatic wait_results(input int n);
        int waited;
        waited = 0;
        while (results.size() < n && waited < result_wait) begin
            idle_cycles(1);
            waited++;
        end
        if (results.size() < n) begin
            $display("only %0d of %0d results arrived by %0t", results.size(), n, $time);
            err_count++;
        end
    endtask

    task automatic check_result(
        input rv32i_types::to_writeback_t got,
        input rv32i_types::to_writeback_t exp,
        input string                      what
    );
        if (got !== exp) begin
            $display("ERR %0t: %s pc=%h got en=%b tgt=%h rd=%h, exp en=%b tgt=%h rd=%h",
                     $time, what, exp.pc, got.br_en, got.pc_new, got.rd_data,
                     exp.br_en, exp.pc_new, exp.rd_data);
            err_count++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("ERR %0t: %s count %0d, expected %0d", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        if (err_count == errs_at_start) begin
            $display("%s: pass", name);
        end else begin
            $display("%s: failed with %0d errors", name, err_count - errs_at_start);
            tests_failed++;
        end
    endtask

    task automatic jumps_redirect();
        rv32i_types::br_dispatch_t  d;
        rv32i_types::to_writeback_t exp_w;
        int                         start;
        int                         waited;
        start = err_count;
        if (station_full !== 1'b0 || wb_out.valid !== 1'b0 || redirect !== 1'b0) begin
            $display("ERR %0t: outputs not idle after reset", $time);
            err_count++;
        end
        clear_queues();
        d = make_op(rv32i_types::op_b_jal, rv32i_types::branch_f3_beq, 32'h0000_1000,
                    32'h0000_0100, 32'h0, 32'h0, 5'd1);
        exp_w = expected_result(d);
        drive_dispatch(d);
        waited = 0;
        while (redirect !== 1'b1 && waited < result_wait) begin
            idle_cycles(1);
            waited++;
        end
        if (redirect !== 1'b1) begin
            $display("redirect never rose for the jal at %0t", $time);
            err_count++;
        end
        // lands in the redirect cycle and must vanish
        drive_dispatch(make_op(rv32i_types::op_b_br, rv32i_types::branch_f3_beq,
                               32'h0000_1004, 32'h0000_0040, 32'h5, 32'h5, 5'd2));
        idle_cycles(6);
        check_count(results.size(), 1, "jal results");
        check_count(redirects.size(), 1, "jal redirects");
        if (results.size() > 0) check_result(results[0], exp_w, "jal");
        if (redirects.size() > 0 && redirects[0] !== exp_w.pc_new) begin
            $display("ERR %0t: jal redirect_pc %h, expected %h",
                     $time, redirects[0], exp_w.pc_new);
            err_count++;
        end
        clear_queues();
        d = make_op(rv32i_types::op_b_jalr, rv32i_types::branch_f3_beq, 32'h0000_1100,
                    32'hffff_fff0, $random(seed), 32'h0, 5'd3);
        exp_w = expected_result(d);
        drive_dispatch(d);
        wait_results(1);
        idle_cycles(3);
        check_count(results.size(), 1, "jalr results");
        check_count(redirects.size(), 1, "jalr redirects");
        if (results.size() > 0) check_result(results[0], exp_w, "jalr");
        if (redirects.size() > 0 && redirects[0] !== exp_w.pc_new) begin
            $display("ERR %0t: jalr redirect_pc %h, expected %h",
                     $time, redirects[0], exp_w.pc_new);
            err_count++;
        end
        finish_test("jumps and redirect", start);
    endtask

    task automatic cond_branches();
        rv32i_types::branch_f3_t    f3_list [6];
        rv32i_types::br_dispatch_t  d;
        rv32i_types::to_writeback_t exp_w;
        logic [31:0]                a;
        logic [31:0]                b;
        int                         start;
        start      = err_count;
        f3_list[0] = rv32i_types::branch_f3_beq;
        f3_list[1] = rv32i_types::branch_f3_bne;
        f3_list[2] = rv32i_types::branch_f3_blt;
        f3_list[3] = rv32i_types::branch_f3_bge;
        f3_list[4] = rv32i_types::branch_f3_bltu;
        f3_list[5] = rv32i_types::branch_f3_bgeu;
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 6; k++) begin
                // equal, sign boundary, then random pairs
                case (k)
                    0: begin
                        a = $random(seed);
                        b = a;
                    end
                    1: begin
                        a = 32'h7fff_ffff;
                        b = 32'h8000_0000;
                    end
                    2: begin
                        a = 32'h8000_0000;
                        b = 32'h7fff_ffff;
                    end
                    3: begin
                        a = 32'h0;
                        b = 32'hffff_ffff;
                    end
                    default: begin
                        a = $random(seed);
                        b = $random(seed);
                    end
                endcase
                clear_queues();
                d = make_op(rv32i_types::op_b_br, f3_list[i], 32'h0000_2000 + i * 64 + k * 4,
                            (k % 2 == 0) ? 32'hffff_ff80 : 32'h0000_0240, a, b, 5'd4);
                exp_w = expected_result(d);
                drive_dispatch(d);
                wait_results(1);
                idle_cycles(2);
                check_count(results.size(), 1, "branch results");
                if (results.size() > 0) check_result(results[0], exp_w, "branch");
                check_count(redirects.size(), exp_w.br_en ? 1 : 0, "branch redirects");
            end
        end
        finish_test("conditional branches", start);
    endtask

    task automatic operand_wakeup();
        rv32i_types::br_dispatch_t d1;
        rv32i_types::br_dispatch_t d2;
        int                        start;
        start = err_count;
        clear_queues();
        // stale rs1 would make the blt taken
        d1 = make_op(rv32i_types::op_b_br, rv32i_types::branch_f3_blt, 32'h0000_4000,
                     32'h0000_0080, 32'hdead_beef, 32'd100, 5'd5);
        d1.rs1_ready   = 1'b0;
        d1.rs1_rob_idx = 5'd7;
        // stale rs2 would make the bne taken
        d2 = make_op(rv32i_types::op_b_br, rv32i_types::branch_f3_bne, 32'h0000_4004,
                     32'h0000_0080, 32'h1234, 32'h0, 5'd6);
        d2.rs2_ready   = 1'b0;
        d2.rs2_rob_idx = 5'd8;
        drive_dispatch(d1);
        // rs2 of the younger entry arrives on the cdb in its dispatch cycle
        dispatch_in    = d2;
        cdb_in.valid   = 1'b1;
        cdb_in.rob_idx = 5'd8;
        cdb_in.data    = 32'h1234;
        idle_cycles(1);
        dispatch_in = '0;
        cdb_in      = '0;
        d2.rs2_data = 32'h1234;
        idle_cycles(3);
        broadcast_cdb(5'd3, 32'h1);
        idle_cycles(3);
        check_count(results.size(), 0, "results before wakeup");
        broadcast_cdb(5'd7, 32'd500);
        wait_results(2);
        idle_cycles(2);
        check_count(results.size(), 2, "wakeup results");
        d1.rs1_data = 32'd500;
        if (results.size() > 0) check_result(results[0], expected_result(d1), "woken head");
        if (results.size() > 1) check_result(results[1], expected_result(d2), "younger entry");
        check_count(redirects.size(), 0, "wakeup redirects");
        finish_test("cdb wakeup", start);
    endtask

    task automatic flush_queue();
        rv32i_types::br_dispatch_t jr;
        rv32i_types::br_dispatch_t d [2];
        int                        start;
        start = err_count;
        clear_queues();
        jr = make_op(rv32i_types::op_b_jalr, rv32i_types::branch_f3_beq, 32'h0000_3000,
                     32'h0000_0010, 32'h0, 32'h0, 5'd12);
        jr.rs1_ready   = 1'b0;
        jr.rs1_rob_idx = 5'd9;
        drive_dispatch(jr);
        for (int i = 0; i < 3; i++) begin
            drive_dispatch(make_op(rv32i_types::op_b_br, rv32i_types::branch_f3_beq,
                                   32'h0000_3004 + i * 4, 32'h40, 32'h9, 32'h9, 5'd13 + i));
        end
        broadcast_cdb(5'd9, 32'h0000_8000);
        wait_results(1);
        idle_cycles(6);
        jr.rs1_data = 32'h0000_8000;
        check_count(results.size(), 1, "results after flush");
        check_count(redirects.size(), 1, "flush redirects");
        if (results.size() > 0) check_result(results[0], expected_result(jr), "flushing jalr");
        if (station_full !== 1'b0) begin
            $display("ERR %0t: station_full high after flush", $time);
            err_count++;
        end
        clear_queues();
        for (int i = 0; i < 2; i++) begin
            d[i] = make_op(rv32i_types::op_b_br, rv32i_types::branch_f3_bne,
                           32'h0000_8000 + i * 4, 32'h80, 32'h77, 32'h77, 5'd20 + i);
            drive_dispatch(d[i]);
        end
        wait_results(2);
        idle_cycles(2);
        check_count(results.size(), 2, "results after refill");
        for (int i = 0; i < 2 && i < results.size(); i++) begin
            check_result(results[i], expected_result(d[i]), "post flush");
        end
        finish_test("flush", start);
    endtask

    task automatic full_and_stall();
        rv32i_types::br_dispatch_t  d [4];
        rv32i_types::to_writeback_t held;
        int                         start;
        int                         waited;
        start = err_count;
        clear_queues();
        wb_stall = 1'b1;
        // only the last entry is taken
        for (int i = 0; i < rv32i_types::br_rs_depth; i++) begin
            d[i] = make_op(rv32i_types::op_b_br, rv32i_types::branch_f3_bgeu,
                           32'h0000_5000 + i * 4, 32'h100, (i == 3) ? 32'h20 : i,
                           32'h10, 5'd24 + i);
            drive_dispatch(d[i]);
        end
        if (station_full !== 1'b1) begin
            $display("ERR %0t: station_full low with four entries", $time);
            err_count++;
        end
        // ignored since the station is full
        drive_dispatch(make_op(rv32i_types::op_b_br, rv32i_types::branch_f3_bgeu,
                               32'h0000_5010, 32'h100, 32'h0, 32'h10, 5'd30));
        // one free cycle loads the head before the hold
        wb_stall = 1'b0;
        idle_cycles(1);
        wb_stall = 1'b1;
        held = wb_out;
        check_result(held, expected_result(d[0]), "stalled head");
        repeat (4) begin
            idle_cycles(1);
            if (wb_out !== held) begin
                $display("ERR %0t: wb_out changed while stalled", $time);
                err_count++;
            end
        end
        wb_stall = 1'b0;
        waited   = 0;
        while (redirect !== 1'b1 && waited < result_wait) begin
            idle_cycles(1);
            waited++;
        end
        if (redirect !== 1'b1) begin
            $display("redirect never rose for the taken entry at %0t", $time);
            err_count++;
        end
        // hold the taken result from its redirect cycle on
        wb_stall = 1'b1;
        idle_cycles(3);
        wb_stall = 1'b0;
        wait_results(4);
        idle_cycles(3);
        check_count(results.size(), 4, "results after release");
        check_count(redirects.size(), 1, "stall redirects");
        for (int i = 0; i < 4 && i < results.size(); i++) begin
            check_result(results[i], expected_result(d[i]), "released");
        end
        finish_test("full and stall", start);
    endtask

    // ends a hung run
    initial begin
        #(test_count * cycles_per_test * 20 + 10 * 20);
        $display("watchdog expired before the tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        dispatch_in  = '0;
        cdb_in       = '0;
        wb_stall     = 1'b0;
        err_count    = 0;
        tests_failed = 0;
        seed         = 32'heca10299;
        wait (rst_n === 1'b1);
        idle_cycles(1);
        jumps_redirect();
        cond_branches();
        operand_wakeup();
        flush_queue();
        full_and_stall();
        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 test_count, tests_failed, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== build.f ====
verilog/rv32i_types.sv
verilog/br_station.sv
verilog/br_unit.sv
verilog/br_complete.sv
verilog/br_exec_top.sv
sim/tb_clk_gen.sv
sim/br_exec_tb.sv
